// ==== core_props.sv ====
`timescale 1ns/100ps
`include "riscv_defs.svh"

module core_props
    import riscv_pipe_pkg::*;
(
    input logic                    id_ex_clk,
    input logic                    id_ex_res,
    input logic [`IMEM_ADDR_W-1:0] imem_addr,
    input dmem_req_t               dmem_req,
    input logic                    load_use_stall
);

    int fail_count = 0;     // failed assertions so far

    read_write_exclusive: assert property (@(posedge id_ex_clk) disable iff (!id_ex_res)
        !(dmem_req.wen && dmem_req.ren))
        else begin
            fail_count++;
            $error("wen and ren high in the same cycle");
        end

    quiet_in_reset: assert property (@(posedge id_ex_clk)
        !id_ex_res |-> !dmem_req.wen && !dmem_req.ren)
        else begin
            fail_count++;
            $error("memory access while reset is active");
        end

    // pc and if/id hold for the stalled cycle
    fetch_holds_on_stall: assert property (@(posedge id_ex_clk) disable iff (!id_ex_res)
        load_use_stall |=> $stable(imem_addr))
        else begin
            fail_count++;
            $error("fetch address moved after a load-use stall");
        end

endmodule

bind riscv_core core_props core_props_i (
    .id_ex_clk      (id_ex_clk),
    .id_ex_res      (id_ex_res),
    .imem_addr      (imem_addr),
    .dmem_req       (dmem_req),
    .load_use_stall (load_use_stall)
);

// ==== core_tests.txt ====
// per test, all hex: program word count and words, data word count and words,
// store count and then address/data pairs; the first word is the number of tests
4
// add/sub chains through both forwarding paths
a 00002083 00402103 00000233 002081b3 401182b3 00328333 00602423 402303b3
  00702623 00000063
2 00000005 00000003
2 00000008 0000000b 0000000c 00000008
// loads followed at once by users of the loaded value
a 00402083 00002103 001101b3 00302823 00802203 00402a23 00002283 40128333
  00602c23 00000063
3 00000100 00000023 00000040
3 00000010 00000123 00000014 00000040 00000018 000000dd
// beq not taken, then taken over three stores
b 00002083 00402103 00802183 00308463 02102023 00208863 02302223 02302423
  02302823 02202623 00000063
3 00000007 00000007 00000009
2 00000020 00000007 0000002c 00000007
// negative store offsets and a write to x0
8 00002083 00402103 00208033 fe00ae23 fe20ac23 002001b3 fe30a823 00000063
2 00000040 00000055
3 0000003c 00000000 00000038 00000055 00000030 00000055

// ==== decode_unit.sv ====
`timescale 1ns/100ps
`include "riscv_defs.svh"

module decode_unit
    import riscv_isa_pkg::*, riscv_pipe_pkg::*;
(
    input  logic   id_ex_clk,
    input  logic   id_ex_res,
    input  if_id_t if_id,
    input  wb_t    wb,
    output id_ex_t id_next
);

    logic [`XLEN-1:0]       regs [`NUM_REGS];
    logic [`XLEN-1:0]       instr;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    opcode_e                opcode;
    ctrl_t                  ctrl;
    logic [`XLEN-1:0]       imm;

    assign instr  = if_id.instr;
    assign opcode = opcode_e'(instr[6:0]);
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    // ============================================================
    // control and immediate decode
    // ============================================================

    always_comb begin
        ctrl = '0;
        imm  = '0;
        case (opcode)
            OP_R: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = instr[30] ? ALU_SUB : ALU_ADD;
            end
            OP_LOAD: begin
                ctrl.mem_read   = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.alu_src    = 1'b1;
                ctrl.reg_write  = 1'b1;
                imm = {{(`XLEN-12){instr[31]}}, instr[31:20]};
            end
            OP_STORE: begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                imm = {{(`XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
            end
            OP_BRANCH: begin
                ctrl.branch = 1'b1;
                imm = {{(`XLEN-12){instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            default: ;                                  // unknown opcode acts as bubble
        endcase
    end

    // ============================================================
    // register file, written on the falling edge
    // ============================================================

    always_ff @(negedge id_ex_clk or negedge id_ex_res) begin
        if (!id_ex_res) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.reg_write && wb.rd != '0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    always_comb begin
        id_next.ctrl     = ctrl;
        id_next.pc       = if_id.pc;
        id_next.imm      = imm;
        id_next.rs1_data = regs[rs1];                   // x0 is never written
        id_next.rs2_data = regs[rs2];
        id_next.rs1      = rs1;
        id_next.rs2      = rs2;
        id_next.rd       = instr[11:7];
    end

endmodule

// ==== execute_unit.sv ====
`timescale 1ns/100ps
`include "riscv_defs.svh"

module execute_unit
    import riscv_isa_pkg::*, riscv_pipe_pkg::*;
(
    input  logic             id_ex_clk,
    input  logic             id_ex_res,
    input  id_ex_t           id_next,
    input  wb_t              wb,
    output ex_mem_t          ex_mem,
    output logic             load_use_stall,
    output logic             branch_taken,
    output logic [`XLEN-1:0] branch_target
);

    id_ex_t           id_ex_q;
    ex_mem_t          ex_mem_q;
    logic [1:0]       fwd_a;
    logic [1:0]       fwd_b;
    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] alu_b;
    logic [`XLEN-1:0] alu_y;

    // 2'b10 from ex/mem, 2'b01 from write-back, 2'b00 register value
    function automatic logic [1:0] fwd_sel(input logic [`REG_ADDR_W-1:0] rs);
        fwd_sel = 2'b00;
        if (ex_mem_q.reg_write && ex_mem_q.rd != '0 && ex_mem_q.rd == rs) begin
            fwd_sel = 2'b10;
        end else if (wb.reg_write && wb.rd != '0 && wb.rd == rs) begin
            fwd_sel = 2'b01;
        end
    endfunction

    always_comb begin
        fwd_a = fwd_sel(id_ex_q.rs1);
        fwd_b = fwd_sel(id_ex_q.rs2);
        case (fwd_a)
            2'b10:   op_a = ex_mem_q.alu_result;
            2'b01:   op_a = wb.data;
            default: op_a = id_ex_q.rs1_data;
        endcase
        case (fwd_b)
            2'b10:   op_b = ex_mem_q.alu_result;
            2'b01:   op_b = wb.data;
            default: op_b = id_ex_q.rs2_data;
        endcase
        alu_b = id_ex_q.ctrl.alu_src ? id_ex_q.imm : op_b;
        alu_y = (id_ex_q.ctrl.alu_op == ALU_SUB) ? op_a - alu_b : op_a + alu_b;
    end

    assign branch_taken   = id_ex_q.ctrl.branch && (op_a == op_b);
    assign branch_target  = id_ex_q.pc + id_ex_q.imm;
    assign load_use_stall = id_ex_q.ctrl.mem_read && id_ex_q.rd != '0 &&
                            (id_ex_q.rd == id_next.rs1 || id_ex_q.rd == id_next.rs2);

    // ============================================================
    // id/ex and ex/mem registers
    // ============================================================

    always_ff @(posedge id_ex_clk or negedge id_ex_res) begin
        if (!id_ex_res) begin
            id_ex_q  <= '0;
            ex_mem_q <= '0;
        end else begin
            id_ex_q  <= (load_use_stall || branch_taken) ? '0 : id_next;   // bubble
            ex_mem_q <= '{mem_read:   id_ex_q.ctrl.mem_read,
                          mem_write:  id_ex_q.ctrl.mem_write,
                          mem_to_reg: id_ex_q.ctrl.mem_to_reg,
                          reg_write:  id_ex_q.ctrl.reg_write,
                          alu_result: alu_y,
                          store_data: op_b,
                          rd:         id_ex_q.rd};
        end
    end

    assign ex_mem = ex_mem_q;

endmodule

// ==== fetch_unit.sv ====
`timescale 1ns/100ps
`include "riscv_defs.svh"

module fetch_unit
    import riscv_pipe_pkg::*;
(
    input  logic                    id_ex_clk,
    input  logic                    id_ex_res,
    input  logic                    load_use_stall,
    input  logic                    branch_taken,
    input  logic [`XLEN-1:0]        branch_target,
    input  logic [`XLEN-1:0]        imem_data,
    output logic [`IMEM_ADDR_W-1:0] imem_addr,
    output if_id_t                  if_id
);

    logic [`XLEN-1:0] pc_q;
    if_id_t           if_id_q;

    always_ff @(posedge id_ex_clk or negedge id_ex_res) begin
        if (!id_ex_res) begin
            pc_q    <= '0;
            if_id_q <= '0;
        end else if (branch_taken) begin
            pc_q    <= branch_target;
            if_id_q <= '{pc: pc_q, instr: '0};      // zero word decodes to no controls
        end else if (!load_use_stall) begin
            pc_q    <= pc_q + `PC_STEP;
            if_id_q <= '{pc: pc_q, instr: imem_data};
        end
    end

    assign imem_addr = pc_q[`IMEM_ADDR_W+1:2];      // byte pc to word address
    assign if_id     = if_id_q;

endmodule

// ==== riscv_core.sv ====
`timescale 1ns/100ps
`include "riscv_defs.svh"

module riscv_core
    import riscv_pipe_pkg::*;
(
    input  logic                    id_ex_clk,
    input  logic                    id_ex_res,
    output logic [`IMEM_ADDR_W-1:0] imem_addr,
    input  logic [`XLEN-1:0]        imem_data,
    output dmem_req_t               dmem_req,
    input  logic [`XLEN-1:0]        dmem_rdata
);

    if_id_t           if_id;
    id_ex_t           id_next;
    ex_mem_t          ex_mem;
    wb_t              wb;
    logic             load_use_stall;
    logic             branch_taken;
    logic [`XLEN-1:0] branch_target;

    fetch_unit fetch_unit_i (
        .id_ex_clk      (id_ex_clk),
        .id_ex_res      (id_ex_res),
        .load_use_stall (load_use_stall),
        .branch_taken   (branch_taken),
        .branch_target  (branch_target),
        .imem_data      (imem_data),
        .imem_addr      (imem_addr),
        .if_id          (if_id)
    );

    decode_unit decode_unit_i (
        .id_ex_clk (id_ex_clk),
        .id_ex_res (id_ex_res),
        .if_id     (if_id),
        .wb        (wb),
        .id_next   (id_next)
    );

    execute_unit execute_unit_i (
        .id_ex_clk      (id_ex_clk),
        .id_ex_res      (id_ex_res),
        .id_next        (id_next),
        .wb             (wb),
        .ex_mem         (ex_mem),
        .load_use_stall (load_use_stall),
        .branch_taken   (branch_taken),
        .branch_target  (branch_target)
    );

    writeback_unit writeback_unit_i (
        .id_ex_clk  (id_ex_clk),
        .id_ex_res  (id_ex_res),
        .ex_mem     (ex_mem),
        .dmem_rdata (dmem_rdata),
        .wb         (wb)
    );

    // memory stage request straight from ex/mem
    assign dmem_req = '{addr:  ex_mem.alu_result,
                        wdata: ex_mem.store_data,
                        wen:   ex_mem.mem_write,
                        ren:   ex_mem.mem_read};

endmodule

// ==== riscv_defs.svh ====
`ifndef RISCV_DEFS_SVH
`define RISCV_DEFS_SVH

// ============================================================
// core widths and sizes
// ============================================================

`define XLEN        32      // data and pc width
`define REG_ADDR_W  5
`define NUM_REGS    32

// ============================================================
// fetch
// ============================================================

`define IMEM_ADDR_W 8       // instruction word address bits
`define PC_STEP     4       // one 32-bit instruction

`endif

// ==== riscv_isa_pkg.sv ====
package riscv_isa_pkg;

    // ============================================================
    // instruction level types
    // ============================================================

    typedef enum logic [6:0] {
        OP_R      = 7'b0110011,     // add, sub
        OP_LOAD   = 7'b0000011,     // lw
        OP_STORE  = 7'b0100011,     // sw
        OP_BRANCH = 7'b1100011      // beq
    } opcode_e;

    typedef enum logic {
        ALU_ADD = 1'b0,
        ALU_SUB = 1'b1
    } alu_op_e;

    // decoded controls, all zero for a bubble
    typedef struct packed {
        logic    branch;
        logic    mem_read;
        logic    mem_write;
        logic    mem_to_reg;        // write back load data
        logic    alu_src;           // second operand from immediate
        logic    reg_write;
        alu_op_e alu_op;
    } ctrl_t;

endpackage

// ==== riscv_pipe_pkg.sv ====
`include "riscv_defs.svh"

package riscv_pipe_pkg;

    import riscv_isa_pkg::*;

    // ============================================================
    // pipeline registers
    // ============================================================

    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] instr;
    } if_id_t;

    typedef struct packed {
        ctrl_t                 ctrl;
        logic [`XLEN-1:0]      pc;
        logic [`XLEN-1:0]      imm;
        logic [`XLEN-1:0]      rs1_data;
        logic [`XLEN-1:0]      rs2_data;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rd;
    } id_ex_t;

    typedef struct packed {
        logic                   mem_read;
        logic                   mem_write;
        logic                   mem_to_reg;
        logic                   reg_write;
        logic [`XLEN-1:0]       alu_result;     // also the memory address
        logic [`XLEN-1:0]       store_data;
        logic [`REG_ADDR_W-1:0] rd;
    } ex_mem_t;

    typedef struct packed {
        logic                   reg_write;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       data;
    } wb_t;

    // data memory port, plain levels
    typedef struct packed {
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] wdata;
        logic             wen;
        logic             ren;
    } dmem_req_t;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
# build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_riscv_core -f sources.f -o sim_riscv_core
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_riscv_core +verilator+error+limit+100)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Simulation completed successfully"; then
    exit 0
fi
exit 1

// ==== sources.f ====
+incdir+.
riscv_isa_pkg.sv
riscv_pipe_pkg.sv
fetch_unit.sv
decode_unit.sv
execute_unit.sv
writeback_unit.sv
riscv_core.sv
core_props.sv
tb_riscv_core.sv

// ==== tb_riscv_core.sv ====
`timescale 1ns/100ps
`include "riscv_defs.svh"

module tb_riscv_core
    import riscv_pipe_pkg::*;
();

    localparam int CLK_PERIOD      = 8;
    localparam int RESET_CYCLES    = 10;
    localparam int RUN_LIMIT       = 150;   // cycles per test before giving up on stores
    localparam int DRAIN_CYCLES    = 12;    // quiet cycles after the last expected store
    localparam int WATCHDOG_CYCLES = 200;   // per test
    localparam int TEST_WORDS      = 512;
    localparam int DMEM_ADDR_W     = 6;

    logic                    id_ex_clk = 1'b0;
    logic                    id_ex_res;
    logic [`IMEM_ADDR_W-1:0] imem_addr;
    logic [`XLEN-1:0]        imem_data;
    dmem_req_t               dmem_req;
    logic [`XLEN-1:0]        dmem_rdata;

    logic [`XLEN-1:0] imem [2**`IMEM_ADDR_W];
    logic [`XLEN-1:0] dmem [2**DMEM_ADDR_W];
    logic [`XLEN-1:0] test_words [TEST_WORDS];
    dmem_req_t        exp_stores [$];

    int num_tests = 0;
    int value_errors = 0;
    int missing_stores = 0;
    int setup_errors = 0;

    riscv_core riscv_core_i (
        .id_ex_clk  (id_ex_clk),
        .id_ex_res  (id_ex_res),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata)
    );

    always #(CLK_PERIOD / 2) id_ex_clk = ~id_ex_clk;

    assign imem_data  = imem[imem_addr];                        // combinational reads
    assign dmem_rdata = dmem[dmem_req.addr[DMEM_ADDR_W+1:2]];

    // ============================================================
    // checks
    // ============================================================

    task automatic check_fetch_addr(input logic [`IMEM_ADDR_W-1:0] got,
                                    input logic [`IMEM_ADDR_W-1:0] exp);
        if (got !== exp) begin
            value_errors++;
            $display("ERR %0t: fetch address %0h, expected %0h", $time, got, exp);
        end
    endtask

    task automatic check_idle(input dmem_req_t got);
        if (got.wen !== 1'b0 || got.ren !== 1'b0) begin
            value_errors++;
            $display("ERR %0t: memory access before the first instruction reached memory", $time);
        end
    endtask

    task automatic check_store(input dmem_req_t got, input dmem_req_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("ERR %0t: store [%0h] = %0h, expected [%0h] = %0h",
                     $time, got.addr, got.wdata, exp.addr, exp.wdata);
        end
    endtask

    // ============================================================
    // memory set-up and test runner
    // ============================================================

    task automatic load_test(inout int ptr);
        int        count;
        int        i;
        dmem_req_t exp;
        for (i = 0; i < 2**`IMEM_ADDR_W; i++) begin
            imem[i] = {i[7:0], 24'h000000};                     // opcode 0 decodes as a bubble
        end
        for (i = 0; i < 2**DMEM_ADDR_W; i++) begin
            dmem[i] = {16'hda7a, i[15:0]};
        end
        count = test_words[ptr];
        ptr++;
        for (i = 0; i < count; i++) begin
            imem[i] = test_words[ptr];
            ptr++;
        end
        count = test_words[ptr];
        ptr++;
        for (i = 0; i < count; i++) begin
            dmem[i] = test_words[ptr];
            ptr++;
        end
        exp_stores.delete();
        count = test_words[ptr];
        ptr++;
        for (i = 0; i < count; i++) begin
            exp.addr  = test_words[ptr];
            exp.wdata = test_words[ptr+1];
            exp.wen   = 1'b1;
            exp.ren   = 1'b0;
            exp_stores.push_back(exp);
            ptr += 2;
        end
    endtask

    initial begin
        int        ptr;
        int        t;
        int        i;
        int        got;
        int        cycles;
        int        quiet;
        int        assert_fails;
        dmem_req_t req;
        id_ex_res = 1'b0;
        for (i = 0; i < TEST_WORDS; i++) begin
            test_words[i] = '0;
        end
        $readmemh("core_tests.txt", test_words);
        num_tests = test_words[0];
        ptr = 1;
        if (num_tests <= 0) begin
            setup_errors++;
            $display("no tests could be read from core_tests.txt");
        end
        for (t = 0; t < num_tests; t++) begin
            id_ex_res = 1'b0;
            load_test(ptr);
            repeat (RESET_CYCLES) @(negedge id_ex_clk);
            id_ex_res = 1'b1;
            check_fetch_addr(imem_addr, '0);
            cycles = 0;
            quiet  = 0;
            got    = 0;
            while (cycles < RUN_LIMIT && quiet < DRAIN_CYCLES) begin
                @(posedge id_ex_clk);
                req = dmem_req;                                 // value before the edge
                if (cycles < 3) begin
                    check_idle(req);                            // first instruction is in fetch..execute
                end
                if (req.wen) begin
                    if (got < exp_stores.size()) begin
                        check_store(req, exp_stores[got]);
                    end else begin
                        value_errors++;
                        $display("ERR %0t: unexpected store [%0h] = %0h",
                                 $time, req.addr, req.wdata);
                    end
                    got++;
                    dmem[req.addr[DMEM_ADDR_W+1:2]] = req.wdata;
                end
                if (got >= exp_stores.size()) begin
                    quiet++;
                end
                cycles++;
            end
            if (got < exp_stores.size()) begin
                missing_stores += exp_stores.size() - got;
                $display("test %0d: missing store, only %0d of %0d stores were seen",
                         t, got, exp_stores.size());
            end
            @(negedge id_ex_clk);
        end
        assert_fails = riscv_core_i.core_props_i.fail_count;
        $display("errors: %0d value, %0d missing store, %0d set-up, %0d assertion",
                 value_errors, missing_stores, setup_errors, assert_fails);
        if (value_errors == 0 && missing_stores == 0 && setup_errors == 0 && assert_fails == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        wait (num_tests > 0);
        #(num_tests * WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: tests still running after %0d cycles", num_tests * WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== writeback_unit.sv ====
`timescale 1ns/100ps
`include "riscv_defs.svh"

module writeback_unit
    import riscv_pipe_pkg::*;
(
    input  logic             id_ex_clk,
    input  logic             id_ex_res,
    input  ex_mem_t          ex_mem,
    input  logic [`XLEN-1:0] dmem_rdata,
    output wb_t              wb
);

    logic                   reg_write_q;
    logic                   mem_to_reg_q;
    logic [`REG_ADDR_W-1:0] rd_q;
    logic [`XLEN-1:0]       alu_q;
    logic [`XLEN-1:0]       load_q;

    always_ff @(posedge id_ex_clk or negedge id_ex_res) begin
        if (!id_ex_res) begin
            reg_write_q  <= 1'b0;
            mem_to_reg_q <= 1'b0;
        end else begin
            reg_write_q  <= ex_mem.reg_write;
            mem_to_reg_q <= ex_mem.mem_to_reg;
        end
    end

    always_ff @(posedge id_ex_clk) begin
        rd_q   <= ex_mem.rd;
        alu_q  <= ex_mem.alu_result;
        load_q <= dmem_rdata;           // sampled in the request cycle
    end

    assign wb = '{reg_write: reg_write_q, rd: rd_q, data: mem_to_reg_q ? load_q : alu_q};

endmodule
